//--- mult_testdata.txt
// Columns in hex: op a b c imm signed subword stall latency expected
// op 0 mac32, 1 msu32, 2 short, 3 short round, 4 dot8, 5 dot16, 6 mulh, ff ends the list

// MAC and MSU, wrapping at 32 bits
0 00000003 00000005 00000007 0 0 0 0 0 00000016
0 ffffffff 00000002 00000010 0 0 0 0 0 0000000e
0 12345678 00000010 00000001 0 0 0 0 0 23456781
1 00000003 00000005 00000064 0 0 0 0 0 00000055
1 00000010 00000010 00000000 0 0 0 0 0 ffffff00
1 fffffffe 00000003 00000001 0 0 0 0 0 00000007

// Short multiply, subword and signedness, shift by imm
2 00000003 00000004 00000000 0 0 0 0 0 0000000c
2 0005ffff 0007fffe 00000000 0 3 0 0 0 00000002
2 0005ffff 0007fffe 00000000 0 0 0 0 0 fffd0002
2 fffe0001 00030001 00000010 1 3 1 0 0 00000005
2 80000000 00020000 00000000 4 1 1 0 0 fffff000
2 00020000 80000000 00000000 4 2 1 0 0 0ffff000

// Short multiply with rounding
3 00000007 00000003 00000000 2 0 0 0 0 00000005
3 0000fff9 00000003 00000000 2 3 0 0 0 fffffffb
3 00640000 00c80000 00000080 8 3 1 0 0 0000004f

// Upper half, signed 3, signed by unsigned 1, unsigned 0
6 ffffffff ffffffff 00000000 0 0 0 0 4 fffffffe
6 ffffffff ffffffff 00000000 0 3 0 0 4 00000000
6 ffffffff ffffffff 00000000 0 1 0 0 4 ffffffff
6 80000000 80000000 00000000 0 3 0 3 4 40000000
2 00000009 00000007 00000005 0 0 0 0 0 00000044
6 00010000 00010000 00000000 0 0 0 0 4 00000001
6 fffe0000 00030000 00000000 0 3 0 0 4 fffffffa
6 80000000 80000000 00000000 0 1 0 0 4 c0000000
6 12345678 00000100 00000000 0 0 0 0 4 00000012
6 7fffffff 7fffffff 00000000 0 3 0 0 4 3fffffff
6 7fffffff ffffffff 00000000 0 1 0 0 4 7ffffffe
6 ffffffff 00000001 00000000 0 3 0 1 4 ffffffff
3 0000fff9 00000003 00000000 2 3 0 0 0 fffffffb

// Dot products, signed bit 1 for A and bit 0 for B
4 01020304 05060708 00000000 0 0 0 0 0 00000046
4 ff02fe04 0106ff08 00000064 0 3 0 0 0 00000091
4 ff02fe04 0106ff08 00000000 0 0 0 0 0 0000fe2d
4 80808080 ffffffff 00000000 0 2 0 0 0 fffe0200
5 00020003 00040005 00000001 0 0 0 0 0 00000018
5 ffff8000 00028000 00000000 0 3 0 0 0 3ffffffe
5 ffff8000 00028000 00000000 0 0 0 0 0 4001fffe
5 ffffffff ffffffff 00000005 0 1 0 0 0 fffe0007

// End marker
ff 00000000 00000000 00000000 0 0 0 0 0 00000000

//--- verilog.f
+incdir+.
mult_pkg.sv
mult_short.sv
mult_mulh_ctrl.sv
mult_dot.sv
mult_unit.sv
tb_mult_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mult_unit
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator from $(FLIST) and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mult_unit.sv
`timescale 1ns/10ps
`include "mult_macros.svh"

module tb_mult_unit import mult_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int FIELDS       = 10;
  localparam int MAX_VEC      = 64;
  localparam int NUM_RAND     = 8;
  localparam logic [31:0] END_OP = 32'h0000_00ff;

  // Column order of one vector in the data file
  localparam int F_OP    = 0;
  localparam int F_A     = 1;
  localparam int F_B     = 2;
  localparam int F_C     = 3;
  localparam int F_IMM   = 4;
  localparam int F_SGN   = 5;
  localparam int F_SUB   = 6;
  localparam int F_STALL = 7;
  localparam int F_LAT   = 8;
  localparam int F_EXP   = 9;

  logic                   clk;
  logic                   rst_n;
  logic                   enable_i;
  mult_op_e               operator_i;
  logic                   short_subword_i;
  logic [1:0]             short_signed_i;
  mult_word_t             op_a_i;
  mult_word_t             op_b_i;
  mult_word_t             op_c_i;
  logic [`MULT_IMM_W-1:0] imm_i;
  logic [1:0]             dot_signed_i;
  mult_word_t             dot_op_a_i;
  mult_word_t             dot_op_b_i;
  mult_word_t             dot_op_c_i;
  logic                   ex_ready_i;
  mult_word_t             result_o;
  logic                   multicycle_o;
  logic                   ready_o;

  logic [31:0]            vec_mem [0:FIELDS*MAX_VEC-1];
  integer                 seed;
  int                     cycle_count;
  int                     cycle_limit;

  mult_unit dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable_i),
    .operator_i      (operator_i),
    .short_subword_i (short_subword_i),
    .short_signed_i  (short_signed_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .imm_i           (imm_i),
    .dot_signed_i    (dot_signed_i),
    .dot_op_a_i      (dot_op_a_i),
    .dot_op_b_i      (dot_op_b_i),
    .dot_op_c_i      (dot_op_c_i),
    .result_o        (result_o),
    .multicycle_o    (multicycle_o),
    .ready_o         (ready_o),
    .ex_ready_i      (ex_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("Some tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(input string name, input mult_word_t exp, input mult_word_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_with_failure("Result word mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_with_failure("Status level mismatch");
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (act != exp) begin
      $display("Fail at %0t: ready_o latency expected %0d, got %0d", $time, exp, act);
      stop_with_failure("Ready latency mismatch");
    end
  endtask

  // 32-bit MAC rule, wraps modulo 2^32
  function automatic mult_word_t mac_expect(input mult_op_e op, input mult_word_t a,
                                            input mult_word_t b, input mult_word_t c);
    if (op == MUL_MSU32) begin
      return c - a * b;
    end
    return c + a * b;
  endfunction

  //////////////////////////////
  // Drive and wait
  //////////////////////////////

  // Same operand words feed the short and the dot inputs
  task automatic issue_op(input mult_op_e op, input mult_word_t a, input mult_word_t b,
                          input mult_word_t c, input logic [`MULT_IMM_W-1:0] imm,
                          input logic [1:0] sgn, input logic sub, input int stall);
    @(posedge clk);
    enable_i        <= 1'b1;
    operator_i      <= op;
    op_a_i          <= a;
    op_b_i          <= b;
    op_c_i          <= c;
    imm_i           <= imm;
    short_signed_i  <= sgn;
    short_subword_i <= sub;
    dot_signed_i    <= sgn;
    dot_op_a_i      <= a;
    dot_op_b_i      <= b;
    dot_op_c_i      <= c;
    // Pipeline stalls from the issue cycle when a hold is wanted
    ex_ready_i      <= (stall == 0);
  endtask

  // Sample on the falling edge, away from the drive edge
  task automatic await_and_check(input mult_word_t exp, input int exp_lat, input int stall);
    int lat;
    int s;
    lat = 0;
    @(negedge clk);
    while (!ready_o) begin
      // Busy only after the issue cycle
      check_bit("multicycle_o", lat > 0, multicycle_o);
      @(negedge clk);
      lat++;
    end
    check_latency(exp_lat, lat);
    check_bit("multicycle_o", 1'b0, multicycle_o);
    check_word("result_o", exp, result_o);
    // Held in FINISH until the stage is ready again
    for (s = 1; s <= stall; s++) begin
      @(posedge clk);
      if (s == stall) begin
        ex_ready_i <= 1'b1;
      end
      @(negedge clk);
      check_bit("ready_o", 1'b1, ready_o);
      check_word("result_o", exp, result_o);
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
        $display("Run passed %0d cycles, the DUT never finished", cycle_limit);
        stop_with_failure("Timeout");
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int         nvec;
    int         stall_total;
    int         base;
    mult_op_e   rop;
    mult_word_t ra;
    mult_word_t rb;
    mult_word_t rc;

    rst_n           = 1'b0;
    enable_i        = 1'b0;
    operator_i      = MUL_MAC32;
    short_subword_i = 1'b0;
    short_signed_i  = 2'b00;
    op_a_i          = '0;
    op_b_i          = '0;
    op_c_i          = '0;
    imm_i           = '0;
    dot_signed_i    = 2'b00;
    dot_op_a_i      = '0;
    dot_op_b_i      = '0;
    dot_op_c_i      = '0;
    ex_ready_i      = 1'b1;
    seed            = 32'hdb6d;
    cycle_limit     = 0;

    $readmemh("mult_testdata.txt", vec_mem);
    nvec        = 0;
    stall_total = 0;
    while (nvec < MAX_VEC && vec_mem[nvec*FIELDS + F_OP] !== END_OP) begin
      stall_total += int'(vec_mem[nvec*FIELDS + F_STALL]);
      nvec++;
    end
    if (nvec == 0 || nvec == MAX_VEC) begin
      stop_with_failure("Vector file missing, empty or without end marker");
    end
    cycle_limit = 10 * (nvec + NUM_RAND) + stall_total + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("ready_o", 1'b1, ready_o);
    check_bit("multicycle_o", 1'b0, multicycle_o);

    // Directed vectors from the data file
    for (int v = 0; v < nvec; v++) begin
      base = v * FIELDS;
      issue_op(mult_op_e'(vec_mem[base + F_OP][2:0]), vec_mem[base + F_A],
               vec_mem[base + F_B], vec_mem[base + F_C],
               vec_mem[base + F_IMM][`MULT_IMM_W-1:0], vec_mem[base + F_SGN][1:0],
               vec_mem[base + F_SUB][0], int'(vec_mem[base + F_STALL]));
      await_and_check(vec_mem[base + F_EXP], int'(vec_mem[base + F_LAT]),
                      int'(vec_mem[base + F_STALL]));
    end

    // Random MAC and MSU filler
    for (int r = 0; r < NUM_RAND; r++) begin
      rop = (r % 2 == 1) ? MUL_MSU32 : MUL_MAC32;
      ra  = $random(seed);
      rb  = $random(seed);
      rc  = $random(seed);
      issue_op(rop, ra, rb, rc, '0, 2'b00, 1'b0, 0);
      await_and_check(mac_expect(rop, ra, rb, rc), 0, 0);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

//--- mult_unit.sv
`timescale 1ns/10ps
`include "mult_macros.svh"

module mult_unit import mult_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable_i,
  input  mult_op_e               operator_i,
  // Integer and short multiply
  input  logic                   short_subword_i,
  input  logic [1:0]             short_signed_i,
  input  mult_word_t             op_a_i,
  input  mult_word_t             op_b_i,
  input  mult_word_t             op_c_i,
  input  logic [`MULT_IMM_W-1:0] imm_i,
  // Dot multiply
  input  logic [1:0]             dot_signed_i,
  input  mult_word_t             dot_op_a_i,
  input  mult_word_t             dot_op_b_i,
  input  mult_word_t             dot_op_c_i,
  output mult_word_t             result_o,
  output logic                   multicycle_o,
  output logic                   ready_o,
  input  logic                   ex_ready_i
);

  logic                   mulh_active;
  logic [`MULT_IMM_W-1:0] step_imm;
  logic [1:0]             step_subword;
  logic [1:0]             step_signed;
  logic                   step_shift_arith;
  logic                   carry;
  logic                   mac_carry;
  mult_word_t             mulh_part_q;
  mult_word_t             short_op_c;
  mult_word_t             short_result;
  mult_word_t             dot8_result;
  mult_word_t             dot16_result;
  mult_word_t             int_op_a_msu;
  mult_word_t             int_op_b_msu;
  mult_word_t             int_result;
  logic                   int_is_msu;

  //////////////////////////////
  // 32-bit MAC
  //////////////////////////////

  // MSU uses c + (~a)*b + b = c - a*b
  assign int_is_msu   = (operator_i == MUL_MSU32);
  assign int_op_a_msu = op_a_i ^ {`MULT_WORD_W{int_is_msu}};
  assign int_op_b_msu = op_b_i & {`MULT_WORD_W{int_is_msu}};
  assign int_result   = op_c_i + int_op_b_msu + int_op_a_msu * op_b_i;

  //////////////////////////////
  // Short multiply and mulh
  //////////////////////////////

  // Partial sum of the mulh steps is fed back as the accumulator
  // Cleared in IDLE so STEP0 starts from zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_part_q <= '0;
    end else if (multicycle_o) begin
      mulh_part_q <= short_result;
    end else if (!mulh_active) begin
      mulh_part_q <= '0;
    end
  end

  assign short_op_c = mulh_active ? mulh_part_q : op_c_i;

  mult_short u_short (
    .operator_i         (operator_i),
    .op_a_i             (op_a_i),
    .op_b_i             (op_b_i),
    .op_c_i             (short_op_c),
    .imm_i              (imm_i),
    .short_subword_i    (short_subword_i),
    .short_signed_i     (short_signed_i),
    .mulh_active_i      (mulh_active),
    .step_imm_i         (step_imm),
    .step_subword_i     (step_subword),
    .step_signed_i      (step_signed),
    .step_shift_arith_i (step_shift_arith),
    .carry_i            (carry),
    .mac_carry_o        (mac_carry),
    .result_o           (short_result)
  );

  mult_mulh_ctrl u_mulh_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .enable_i           (enable_i),
    .operator_i         (operator_i),
    .short_signed_i     (short_signed_i),
    .ex_ready_i         (ex_ready_i),
    .mac_carry_i        (mac_carry),
    .mulh_active_o      (mulh_active),
    .step_imm_o         (step_imm),
    .step_subword_o     (step_subword),
    .step_signed_o      (step_signed),
    .step_shift_arith_o (step_shift_arith),
    .carry_o            (carry),
    .multicycle_o       (multicycle_o),
    .ready_o            (ready_o)
  );

  mult_dot u_dot (
    .dot_signed_i   (dot_signed_i),
    .dot_op_a_i     (dot_op_a_i),
    .dot_op_b_i     (dot_op_b_i),
    .dot_op_c_i     (dot_op_c_i),
    .dot8_result_o  (dot8_result),
    .dot16_result_o (dot16_result)
  );

  //////////////////////////////
  // Result mux
  //////////////////////////////

  always_comb begin
    case (operator_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT16:            result_o = dot16_result;
      default:              result_o = '0;
    endcase
  end

  // Decoder never issues the unused code
  a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
    enable_i |-> operator_i inside {MUL_MAC32, MUL_MSU32, MUL_I, MUL_IR,
                                    MUL_H, MUL_DOT8, MUL_DOT16});

endmodule

//--- mult_dot.sv
`timescale 1ns/10ps
`include "mult_macros.svh"

module mult_dot import mult_pkg::*; (
  input  logic [1:0] dot_signed_i,
  input  mult_word_t dot_op_a_i,
  input  mult_word_t dot_op_b_i,
  input  mult_word_t dot_op_c_i,
  output mult_word_t dot8_result_o,
  output mult_word_t dot16_result_o
);

  localparam int BW = `MULT_BYTE_W;
  localparam int HW = `MULT_HALF_W;
  localparam int WW = `MULT_WORD_W;
  localparam int NB = WW / BW;
  localparam int NH = WW / HW;

  dot_word_u                 a_w;
  dot_word_u                 b_w;

  // Lanes carry one extra bit for signed or unsigned extension
  logic [NB-1:0][BW:0]       char_a;
  logic [NB-1:0][BW:0]       char_b;
  logic [NB-1:0][2*BW+1:0]   char_mul;
  logic [NH-1:0][HW:0]       half_a;
  logic [NH-1:0][HW:0]       half_b;
  logic [NH-1:0][2*HW+1:0]   half_mul;
  mult_word_t                dot8_sum;
  mult_word_t                dot16_sum;

  // Same words seen as bytes and as halfwords
  assign a_w = dot_op_a_i;
  assign b_w = dot_op_b_i;

  //////////////////////////////
  // Lane products
  //////////////////////////////

  // Bit 1 of the signedness is for A, bit 0 for B
  always_comb begin
    for (int i = 0; i < NB; i++) begin
      char_a[i]   = {dot_signed_i[1] & a_w.byte_lane[i][BW-1], a_w.byte_lane[i]};
      char_b[i]   = {dot_signed_i[0] & b_w.byte_lane[i][BW-1], b_w.byte_lane[i]};
      char_mul[i] = $signed(char_a[i]) * $signed(char_b[i]);
    end
    for (int j = 0; j < NH; j++) begin
      half_a[j]   = {dot_signed_i[1] & a_w.half_lane[j][HW-1], a_w.half_lane[j]};
      half_b[j]   = {dot_signed_i[0] & b_w.half_lane[j][HW-1], b_w.half_lane[j]};
      half_mul[j] = $signed(half_a[j]) * $signed(half_b[j]);
    end
  end

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  // Byte products sign-extend to the word
  // Halfword products just wrap at 32 bits
  always_comb begin
    dot8_sum  = dot_op_c_i;
    dot16_sum = dot_op_c_i;
    for (int i = 0; i < NB; i++) begin
      dot8_sum = dot8_sum + mult_word_t'($signed(char_mul[i]));
    end
    for (int j = 0; j < NH; j++) begin
      dot16_sum = dot16_sum + half_mul[j][WW-1:0];
    end
  end

  assign dot8_result_o  = dot8_sum;
  assign dot16_result_o = dot16_sum;

endmodule

//--- mult_mulh_ctrl.sv
`timescale 1ns/10ps
`include "mult_macros.svh"

module mult_mulh_ctrl import mult_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable_i,
  input  mult_op_e               operator_i,
  input  logic [1:0]             short_signed_i,
  input  logic                   ex_ready_i,
  input  logic                   mac_carry_i,
  output logic                   mulh_active_o,
  output logic [`MULT_IMM_W-1:0] step_imm_o,
  output logic [1:0]             step_subword_o,
  output logic [1:0]             step_signed_o,
  output logic                   step_shift_arith_o,
  output logic                   carry_o,
  output logic                   multicycle_o,
  output logic                   ready_o
);

  // State codes
  localparam logic [2:0] IDLE   = 3'd0;
  localparam logic [2:0] STEP0  = 3'd1;
  localparam logic [2:0] STEP1  = 3'd2;
  localparam logic [2:0] STEP2  = 3'd3;
  localparam logic [2:0] FINISH = 3'd4;

  logic [2:0] state_q;
  logic [2:0] state_d;
  logic       carry_q;
  logic       save_carry;
  logic       clear_carry;

  //////////////////////////////
  // Step sequencing
  //////////////////////////////

  always_comb begin
    state_d            = state_q;
    step_imm_o         = '0;
    step_subword_o     = 2'b00;
    step_signed_o      = 2'b00;
    step_shift_arith_o = 1'b0;
    mulh_active_o      = 1'b1;
    multicycle_o       = 1'b0;
    ready_o            = 1'b0;
    save_carry         = 1'b0;
    clear_carry        = 1'b0;

    case (state_q)
      IDLE: begin
        mulh_active_o = 1'b0;
        ready_o       = 1'b1;
        // Ready drops in the very cycle the mulh is issued
        if (enable_i && (operator_i == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      STEP0: begin
        // AL*BL is always unsigned and keeps only its upper half
        multicycle_o = 1'b1;
        step_imm_o   = `MULT_IMM_W'(`MULT_HALF_W);
        state_d      = STEP1;
      end
      STEP1: begin
        // AL*BH is signed only if B is
        multicycle_o       = 1'b1;
        step_signed_o      = {short_signed_i[1], 1'b0};
        step_subword_o     = 2'b10;
        step_shift_arith_o = 1'b1;
        // Sign of the 33-bit sum extends the next accumulate
        save_carry         = 1'b1;
        state_d            = STEP2;
      end
      STEP2: begin
        // AH*BL is signed only if A is
        multicycle_o       = 1'b1;
        step_signed_o      = {1'b0, short_signed_i[0]};
        step_subword_o     = 2'b01;
        step_imm_o         = `MULT_IMM_W'(`MULT_HALF_W);
        step_shift_arith_o = 1'b1;
        // Top bits are shifted back in, so no carry survives
        save_carry         = 1'b1;
        clear_carry        = 1'b1;
        state_d            = FINISH;
      end
      FINISH: begin
        // AH*BH with full signedness gives the upper word
        step_signed_o  = short_signed_i;
        step_subword_o = 2'b11;
        ready_o        = 1'b1;
        // Hold result while the pipeline stalls
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////
  // State and carry registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (save_carry) begin
        carry_q <= ~clear_carry & mac_carry_i;
      end else if (ex_ready_i) begin
        // Next instruction starts without a carry
        carry_q <= 1'b0;
      end
    end
  end

  assign carry_o = carry_q;

  // Three busy steps with ready low, then ready in FINISH
  a_busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(multicycle_o) |-> (multicycle_o && !ready_o) ##1 (multicycle_o && !ready_o)
                            ##1 (multicycle_o && !ready_o) ##1 (ready_o && !multicycle_o));

  // Only an issued mulh starts the sequence
  a_idle_start: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == IDLE) && !(enable_i && (operator_i == MUL_H)) |=> (state_q == IDLE));

endmodule

//--- mult_short.sv
`timescale 1ns/10ps
`include "mult_macros.svh"

module mult_short import mult_pkg::*; (
  input  mult_op_e                operator_i,
  input  mult_word_t              op_a_i,
  input  mult_word_t              op_b_i,
  input  mult_word_t              op_c_i,
  input  logic [`MULT_IMM_W-1:0]  imm_i,
  input  logic                    short_subword_i,
  input  logic [1:0]              short_signed_i,
  input  logic                    mulh_active_i,
  input  logic [`MULT_IMM_W-1:0]  step_imm_i,
  input  logic [1:0]              step_subword_i,
  input  logic [1:0]              step_signed_i,
  input  logic                    step_shift_arith_i,
  input  logic                    carry_i,
  output logic                    mac_carry_o,
  output mult_word_t              result_o
);

  localparam int HW = `MULT_HALF_W;
  localparam int WW = `MULT_WORD_W;
  localparam int MW = `MULT_MAC_W;

  logic [`MULT_IMM_W-1:0] short_imm;
  logic [1:0]             short_subword;
  logic [1:0]             short_signed;
  logic                   short_shift_arith;

  logic [HW:0]            short_op_a;
  logic [HW:0]            short_op_b;
  logic [MW-1:0]          short_op_c;
  logic [MW-1:0]          short_mul;
  logic [MW-1:0]          short_mac;
  logic [MW-1:0]          short_shifted;
  mult_word_t             short_round_tmp;
  mult_word_t             short_round;
  logic                   mac_msb1;
  logic                   mac_msb0;

  //////////////////////////////
  // Control select
  //////////////////////////////

  // Step controls win while an upper-half multiply runs
  assign short_imm         = mulh_active_i ? step_imm_i         : imm_i;
  assign short_subword     = mulh_active_i ? step_subword_i     : {2{short_subword_i}};
  assign short_signed      = mulh_active_i ? step_signed_i      : short_signed_i;
  // Plain short ops shift arithmetically iff A is signed
  assign short_shift_arith = mulh_active_i ? step_shift_arith_i : short_signed_i[0];

  //////////////////////////////
  // Multiply and accumulate
  //////////////////////////////

  // Halfword select, bit 0 for A and bit 1 for B
  assign short_op_a[HW-1:0] = short_subword[0] ? op_a_i[WW-1:HW] : op_a_i[HW-1:0];
  assign short_op_b[HW-1:0] = short_subword[1] ? op_b_i[WW-1:HW] : op_b_i[HW-1:0];

  // 17th bit turns the halves into signed or unsigned values
  assign short_op_a[HW] = short_signed[0] & short_op_a[HW-1];
  assign short_op_b[HW] = short_signed[1] & short_op_b[HW-1];

  // Accumulator is 33 bits with the saved carry on top during mulh
  assign short_op_c = mulh_active_i ? {carry_i, carry_i, op_c_i}
                                    : {op_c_i[WW-1], op_c_i[WW-1], op_c_i};

  // Rounding adds half an LSB of the shifted result
  assign short_round_tmp = mult_word_t'(1) << imm_i;
  assign short_round     = (operator_i == MUL_IR) ? {1'b0, short_round_tmp[WW-1:1]} : '0;

  assign short_mul = $signed(short_op_a) * $signed(short_op_b);
  assign short_mac = short_op_c + short_mul + {2'b00, short_round};

  //////////////////////////////
  // Result shift
  //////////////////////////////

  // Mulh keeps the real 34-bit sign, short ops re-extend from bit 31
  assign mac_msb1 = mulh_active_i ? short_mac[MW-1] : short_mac[WW-1];
  assign mac_msb0 = mulh_active_i ? short_mac[WW]   : short_mac[WW-1];

  assign short_shifted = $signed({short_shift_arith & mac_msb1,
                                  short_shift_arith & mac_msb0,
                                  short_mac[WW-1:0]}) >>> short_imm;

  assign result_o    = short_shifted[WW-1:0];
  // Sign of the 33-bit partial sum, saved between mulh steps
  assign mac_carry_o = short_mac[WW];

endmodule

//--- mult_pkg.sv
`include "mult_macros.svh"

package mult_pkg;

  //////////////////////////////
  // Operator encoding
  //////////////////////////////

  // Matches the execution stage decoder
  // Code 3'b111 is unused
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101,
    MUL_H     = 3'b110
  } mult_op_e;

  //////////////////////////////
  // Data types
  //////////////////////////////

  // Operand and result word
  typedef logic [`MULT_WORD_W-1:0] mult_word_t;

  // One dot operand word
  // Lane 0 sits in the low bits in both views
  typedef union packed {
    logic [`MULT_WORD_W/`MULT_BYTE_W-1:0][`MULT_BYTE_W-1:0] byte_lane;
    logic [`MULT_WORD_W/`MULT_HALF_W-1:0][`MULT_HALF_W-1:0] half_lane;
  } dot_word_u;

endpackage

//--- mult_macros.svh
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// Widths shared by the multiplier datapaths and the testbench

// Full operand and result word
`define MULT_WORD_W 32

// Halfword lane
// Also the shift used by the upper-half multiply on its low and cross steps
`define MULT_HALF_W 16

// Byte lane of the dot product
`define MULT_BYTE_W 8

// Shift amount for the short multiply
`define MULT_IMM_W 5

// Sum width of the short MAC
// Two guard bits above the word hold the carry and sign of the mulh steps
`define MULT_MAC_W (`MULT_WORD_W + 2)

`endif
